//--- ucode_ctrl.f
ucode_pkg.sv
microstore_rom.sv
micro_sequencer.sv
accum_datapath.sv
ucu_apb_regs.sv
ucode_ctrl_top.sv
ucode_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, pass only if the log holds the pass message
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module ucode_ctrl_tb -f ucode_ctrl.f -o ucode_ctrl_sim
./obj_dir/ucode_ctrl_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: PASS" sim.log; then
	echo "run_sim: simulation passed"
	exit 0
fi
echo "run_sim: simulation failed, see sim.log"
exit 1

//--- ucode_ctrl_tb.sv
//####################
// testbench for the microprogrammed control unit that drives the APB port of ucode_ctrl_top
// results read back are checked against a reference model of the instruction set
//####################
`timescale 1ns/1ns

module ucode_ctrl_tb;

	localparam int wait_limit = 64; // cycles allowed for any single wait

	logic                             clk = 1'b0;
	logic                             rst_n;
	logic                             psel;
	logic                             penable;
	logic                             pwrite;
	logic [ucode_pkg::apb_addr_w-1:0] paddr;
	logic [ucode_pkg::apb_data_w-1:0] pwdata;
	logic [ucode_pkg::apb_data_w-1:0] prdata;
	logic                             pready;
	logic                             pslverr;

	integer                           seed;
	int                               errors;
	int                               checks;
	int                               tests_run;
	int                               tests_failed;
	int                               errors_at_start;
	string                            cur_test;
	logic [ucode_pkg::data_w-1:0]     model_acc;
	logic [ucode_pkg::done_cnt_w-1:0] exp_done;
	logic [ucode_pkg::err_cnt_w-1:0]  exp_err;

	// acc results waiting for the compare process
	string                            name_q[$];
	logic [ucode_pkg::data_w-1:0]     exp_q[$];
	logic [ucode_pkg::data_w-1:0]     got_q[$];

	always #50 clk = ~clk;

	ucode_ctrl_top u_dut (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	//####################
	// reference model
	function automatic logic [ucode_pkg::data_w-1:0] ref_acc(
		input logic [ucode_pkg::data_w-1:0] prev,
		input ucode_pkg::instr_t            ins
	);
		case (ins.opcode)
			ucode_pkg::op_clr:  ref_acc = '0;
			ucode_pkg::op_load: ref_acc = ins.operand;
			ucode_pkg::op_add:  ref_acc = prev + ins.operand; // wraps modulo 256
			ucode_pkg::op_sub:  ref_acc = prev - ins.operand;
			ucode_pkg::op_xor:  ref_acc = prev ^ ins.operand;
			ucode_pkg::op_shl:  ref_acc = prev << ins.shamt;
			default:            ref_acc = prev;
		endcase
	endfunction

	function automatic ucode_pkg::instr_t mk_instr(
		input ucode_pkg::opcode_t           op,
		input logic [ucode_pkg::cnt_w-1:0]  sh,
		input logic [ucode_pkg::data_w-1:0] val
	);
		mk_instr = '{opcode: op, shamt: sh, operand: val};
	endfunction

	task automatic report_timeout(input string what);
		$display("timeout in test %s: %s", cur_test, what);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	//####################
	// compare tasks
	task automatic check_acc(input string test, input logic [ucode_pkg::data_w-1:0] exp,
		input logic [ucode_pkg::data_w-1:0] got);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s acc: expected 0x%02h, got 0x%02h", test, exp, got);
			errors++;
		end
	endtask

	task automatic check_status(input string what, input ucode_pkg::status_t exp,
		input ucode_pkg::status_t got);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s %s: expected 0x%04h, got 0x%04h", cur_test, what, exp, got);
			errors++;
		end
	endtask

	task automatic check_err(input string what, input logic exp, input logic got);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s %s: expected pslverr %0b, got %0b", cur_test, what, exp, got);
			errors++;
		end
	endtask

	// drains queued acc results at every falling edge
	always @(negedge clk) begin
		while (got_q.size() > 0) begin
			check_acc(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
		end
	end

	//####################
	// APB tasks
	task automatic apb_write(input logic [ucode_pkg::apb_addr_w-1:0] addr,
		input logic [ucode_pkg::apb_data_w-1:0] data, output logic err);
		int   cycles;
		logic got;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		cycles = 0;
		got = 1'b0;
		err = 1'b0;
		while (!got && cycles < wait_limit) begin
			@(posedge clk);
			cycles++;
			if (pready) begin
				got = 1'b1;
				err = pslverr;
			end
		end
		if (!got)
			report_timeout("pready stayed low during a write");
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [ucode_pkg::apb_addr_w-1:0] addr,
		output logic [ucode_pkg::apb_data_w-1:0] data, output logic err, output int stall);
		logic got;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		stall = 0;
		got = 1'b0;
		err = 1'b0;
		data = '0;
		while (!got && stall < wait_limit) begin
			@(posedge clk);
			if (pready) begin
				got = 1'b1;
				err = pslverr;
				data = prdata;
			end else begin
				stall++; // cycle with the read held off
			end
		end
		if (!got)
			report_timeout("pready stayed low during a read");
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	//####################
	// instruction helpers
	task automatic issue_instr(input ucode_pkg::instr_t ins);
		logic err;
		apb_write(ucode_pkg::reg_instr, 32'(ins), err);
		check_err("instr write", 1'b0, err);
		model_acc = ref_acc(model_acc, ins);
		exp_done = exp_done + 1'b1;
	endtask

	task automatic read_acc(output int stall);
		logic                             err;
		logic [ucode_pkg::apb_data_w-1:0] rdata;
		apb_read(ucode_pkg::reg_acc, rdata, err, stall);
		check_err("acc read", 1'b0, err);
		name_q.push_back(cur_test);
		exp_q.push_back(model_acc);
		got_q.push_back(rdata[ucode_pkg::data_w-1:0]);
	endtask

	task automatic run_instr(input ucode_pkg::instr_t ins, output int stall);
		issue_instr(ins);
		read_acc(stall);
	endtask

	task automatic read_and_check_status();
		logic                             err;
		int                               stall;
		logic [ucode_pkg::apb_data_w-1:0] rdata;
		ucode_pkg::status_t               exp_st;
		apb_read(ucode_pkg::reg_status, rdata, err, stall);
		check_err("status read", 1'b0, err);
		exp_st = '{busy: 1'b0, err_cnt: exp_err, done_cnt: exp_done};
		check_status("status", exp_st,
			ucode_pkg::status_t'(rdata[$bits(ucode_pkg::status_t)-1:0]));
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		int cycles;
		cycles = 0;
		while (got_q.size() != 0 && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (got_q.size() != 0) begin
			report_timeout("queued acc results were never compared");
		end else begin
			tests_run++;
			if (errors == errors_at_start) begin
				$display("test %s: passed", cur_test);
			end else begin
				$display("test %s: failed with %0d errors", cur_test, errors - errors_at_start);
				tests_failed++;
			end
		end
	endtask

	//####################
	// test sequence
	initial begin
		logic                             err;
		int                               stall;
		logic [ucode_pkg::apb_data_w-1:0] rdata;
		logic [31:0]                      r_op;
		logic [31:0]                      r_val;
		logic [31:0]                      r_sh;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rst_n = 1'b0;
		seed = 36;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		model_acc = '0;
		exp_done = '0;
		exp_err = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		start_test("reset");
		read_and_check_status();
		read_acc(stall);
		finish_test();

		start_test("simple_ops");
		run_instr(mk_instr(ucode_pkg::op_load, 3'd0, 8'h5a), stall);
		run_instr(mk_instr(ucode_pkg::op_add, 3'd0, 8'h30), stall);
		run_instr(mk_instr(ucode_pkg::op_add, 3'd0, 8'h90), stall); // carries out of bit 7
		run_instr(mk_instr(ucode_pkg::op_sub, 3'd0, 8'h20), stall); // borrows below zero
		run_instr(mk_instr(ucode_pkg::op_xor, 3'd0, 8'hff), stall);
		run_instr(mk_instr(ucode_pkg::op_clr, 3'd0, 8'h77), stall);
		run_instr(mk_instr(ucode_pkg::op_sub, 3'd0, 8'h01), stall);
		run_instr(mk_instr(ucode_pkg::op_load, 3'd0, 8'hc3), stall);
		run_instr(mk_instr(ucode_pkg::op_xor, 3'd0, 8'h3c), stall);
		finish_test();

		start_test("shl_sweep");
		for (int i = 0; i < 8; i++) begin
			run_instr(mk_instr(ucode_pkg::op_load, 3'd0, 8'hb5), stall);
			run_instr(mk_instr(ucode_pkg::op_shl, i[2:0], 8'h00), stall);
			if (stall == 0) begin
				$display("test %s: acc read after SHL by %0d was not held off", cur_test, i);
				errors++;
			end
		end
		finish_test();

		start_test("error_responses");
		run_instr(mk_instr(ucode_pkg::op_load, 3'd0, 8'h81), stall);
		issue_instr(mk_instr(ucode_pkg::op_shl, 3'd7, 8'h00));
		apb_write(ucode_pkg::reg_instr, 32'(mk_instr(ucode_pkg::op_load, 3'd0, 8'h00)), err);
		check_err("instr write while busy", 1'b1, err);
		exp_err = exp_err + 1'b1;
		read_acc(stall);
		apb_write(ucode_pkg::reg_status, 32'h0000_00ff, err);
		check_err("status write", 1'b1, err);
		exp_err = exp_err + 1'b1;
		apb_write(4'hc, 32'h1234_5678, err);
		check_err("unknown offset write", 1'b1, err);
		exp_err = exp_err + 1'b1;
		apb_read(4'hc, rdata, err, stall);
		check_err("unknown offset read", 1'b1, err);
		exp_err = exp_err + 1'b1;
		read_and_check_status();
		finish_test();

		start_test("random_seq");
		for (int i = 0; i < 40; i++) begin
			r_op = $random(seed);
			r_op = r_op % 32'd6;
			r_val = $random(seed);
			r_sh = $random(seed);
			run_instr(mk_instr(ucode_pkg::opcode_t'(r_op[2:0]), r_sh[2:0], r_val[7:0]), stall);
		end
		read_and_check_status(); // done_cnt wraps with the 8-bit model count
		finish_test();

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- ucode_ctrl_top.sv
//####################
// top level of the microprogrammed control unit with an APB port
//####################
`timescale 1ns/1ns

module ucode_ctrl_top (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             psel,
	input  logic                             penable,
	input  logic                             pwrite,
	input  logic [ucode_pkg::apb_addr_w-1:0] paddr,
	input  logic [ucode_pkg::apb_data_w-1:0] pwdata,
	output logic [ucode_pkg::apb_data_w-1:0] prdata,
	output logic                             pready,
	output logic                             pslverr
);

	logic                          start;
	ucode_pkg::instr_t             instr;
	logic [ucode_pkg::uaddr_w-1:0] upc;
	logic [ucode_pkg::uaddr_w-1:0] dispatch_addr;
	ucode_pkg::ucode_word_t        ucw;
	logic                          busy;
	logic                          done;
	logic [ucode_pkg::data_w-1:0]  acc;

	ucu_apb_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.busy(busy), .done(done), .acc(acc), .start(start), .instr(instr)
	);

	micro_sequencer u_seq (
		.clk(clk), .rst_n(rst_n), .start(start), .shamt(instr.shamt),
		.ucw(ucw), .dispatch_addr(dispatch_addr), .upc(upc), .busy(busy), .done(done)
	);

	microstore_rom u_rom (
		.upc(upc), .opcode(instr.opcode), .ucw(ucw), .dispatch_addr(dispatch_addr)
	);

	accum_datapath u_dp (
		.clk(clk), .rst_n(rst_n), .alu_op(ucw.alu_op), .acc_we(ucw.acc_we),
		.operand(instr.operand), .acc(acc)
	);

endmodule

//--- ucu_apb_regs.sv
//####################
// APB slave of the control unit that accepts one instruction at a time
// write INSTR to launch, poll STATUS or read ACC, which stalls until done
//####################
`timescale 1ns/1ns

module ucu_apb_regs (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             psel,
	input  logic                             penable,
	input  logic                             pwrite,
	input  logic [ucode_pkg::apb_addr_w-1:0] paddr,
	input  logic [ucode_pkg::apb_data_w-1:0] pwdata,
	output logic [ucode_pkg::apb_data_w-1:0] prdata,
	output logic                             pready,
	output logic                             pslverr,
	input  logic                             busy,
	input  logic                             done,
	input  logic [ucode_pkg::data_w-1:0]     acc,
	output logic                             start,
	output ucode_pkg::instr_t                instr
);

	logic                                access;
	logic                                busy_any;
	logic                                acc_stall;
	logic                                bad_access;
	logic                                instr_wr;
	logic [ucode_pkg::err_cnt_w-1:0]     err_cnt;
	logic [ucode_pkg::done_cnt_w-1:0]    done_cnt;
	ucode_pkg::status_t                  status;

	assign access   = psel && penable;
	assign busy_any = busy || start; // start covers the cycle before busy rises

	assign acc_stall = access && !pwrite && (paddr == ucode_pkg::reg_acc) && busy_any;
	assign pready    = !acc_stall;

	//####################
	// decode
	always_comb begin
		case (paddr)
			ucode_pkg::reg_instr:  bad_access = pwrite && busy_any;
			ucode_pkg::reg_acc:    bad_access = pwrite;
			ucode_pkg::reg_status: bad_access = pwrite;
			default:               bad_access = 1'b1;
		endcase
	end

	assign pslverr  = access && pready && bad_access;
	assign instr_wr = access && pwrite && (paddr == ucode_pkg::reg_instr) && !bad_access;

	assign status = '{busy: busy_any, err_cnt: err_cnt, done_cnt: done_cnt};

	always_comb begin
		prdata = '0;
		case (paddr)
			ucode_pkg::reg_instr:  prdata[$bits(ucode_pkg::instr_t)-1:0] = instr;
			ucode_pkg::reg_acc:    prdata[ucode_pkg::data_w-1:0] = acc;
			ucode_pkg::reg_status: prdata[$bits(ucode_pkg::status_t)-1:0] = status;
			default:               prdata = '0;
		endcase
	end

	//####################
	// registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			start    <= 1'b0;
			instr    <= '0;
			err_cnt  <= '0;
			done_cnt <= '0;
		end else begin
			start <= instr_wr; // launches on the edge after the write completes
			if (instr_wr)
				instr <= ucode_pkg::instr_t'(pwdata[$bits(ucode_pkg::instr_t)-1:0]);
			if (pslverr)
				err_cnt <= err_cnt + 1'b1;
			if (done)
				done_cnt <= done_cnt + 1'b1; // wraps at 256
		end
	end

	// a held-off access stays in its access phase on the same address
	a_stall_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		!pready |=> psel && penable && $stable(paddr) && $stable(pwrite))
		else $error("APB access left its access phase while pready was low");

endmodule

//--- accum_datapath.sv
//####################
// 8-bit accumulator and ALU steered by the current microword
//####################
`timescale 1ns/1ns

module accum_datapath (
	input  logic                         clk,
	input  logic                         rst_n,
	input  ucode_pkg::alu_op_t           alu_op,
	input  logic                         acc_we,
	input  logic [ucode_pkg::data_w-1:0] operand,
	output logic [ucode_pkg::data_w-1:0] acc
);

	logic [ucode_pkg::data_w-1:0] alu_res;

	//####################
	// ALU
	// all results keep only the low byte so sums and differences wrap
	always_comb begin
		case (alu_op)
			ucode_pkg::alu_pass_acc: alu_res = acc;
			ucode_pkg::alu_zero:     alu_res = '0;
			ucode_pkg::alu_operand:  alu_res = operand;
			ucode_pkg::alu_add:      alu_res = acc + operand;
			ucode_pkg::alu_sub:      alu_res = acc - operand;
			ucode_pkg::alu_xor:      alu_res = acc ^ operand;
			ucode_pkg::alu_shl1:     alu_res = {acc[ucode_pkg::data_w-2:0], 1'b0};
			default:                 alu_res = acc;
		endcase
	end

	//####################
	// accumulator
	always_ff @(posedge clk) begin
		if (!rst_n)
			acc <= '0;
		else if (acc_we)
			acc <= alu_res; // written only by execute and loop words
	end

endmodule

//--- micro_sequencer.sv
//####################
// micro-PC, next-address selection and loop counter
// waits at the idle address until start, then walks the microprogram
//####################
`timescale 1ns/1ns

module micro_sequencer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          start,
	input  logic [ucode_pkg::cnt_w-1:0]   shamt,
	input  ucode_pkg::ucode_word_t        ucw,
	input  logic [ucode_pkg::uaddr_w-1:0] dispatch_addr,
	output logic [ucode_pkg::uaddr_w-1:0] upc,
	output logic                          busy,
	output logic                          done
);

	logic [ucode_pkg::uaddr_w-1:0] upc_nxt;
	logic [ucode_pkg::cnt_w-1:0]   cnt;
	logic [ucode_pkg::cnt_w-1:0]   cnt_nxt;
	logic                          at_idle;

	assign at_idle = (upc == ucode_pkg::uaddr_idle);

	// the loop test looks at the count this word leaves behind
	always_comb begin
		cnt_nxt = cnt;
		if (ucw.cnt_load)
			cnt_nxt = shamt;
		else if (ucw.cnt_dec)
			cnt_nxt = cnt - 1'b1;
	end

	//####################
	// next address
	always_comb begin
		upc_nxt = upc + 1'b1;
		if (at_idle && !start) begin
			upc_nxt = upc; // park until launched
		end else if (ucw.done) begin
			upc_nxt = ucode_pkg::uaddr_idle;
		end else begin
			case (ucw.next_sel)
				ucode_pkg::nx_seq:      upc_nxt = upc + 1'b1;
				ucode_pkg::nx_jump:     upc_nxt = ucw.next_addr;
				ucode_pkg::nx_dispatch: upc_nxt = dispatch_addr;
				ucode_pkg::nx_loop: begin
					if (cnt_nxt != '0)
						upc_nxt = ucw.next_addr;
				end
				default:                upc_nxt = ucode_pkg::uaddr_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			upc  <= ucode_pkg::uaddr_idle;
			cnt  <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			upc  <= upc_nxt;
			cnt  <= cnt_nxt;
			done <= busy && ucw.done; // one pulse per finished instruction
			if (at_idle && start)
				busy <= 1'b1;
			else if (ucw.done)
				busy <= 1'b0;
		end
	end

	//####################
	// checks
	a_no_loop_at_idle: assert property (@(posedge clk) disable iff (!rst_n)
		at_idle |-> ucw.next_sel != ucode_pkg::nx_loop)
		else $error("microstore holds a loop word at the idle address");

	a_busy_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(busy) |-> $past(start) && !at_idle)
		else $error("busy rose without a start that moved the micro-PC off idle");

endmodule

//--- microstore_rom.sv
//####################
// microstore of the control unit, addressed by the micro-PC
// also holds the opcode dispatch table used by the idle word
//####################
`timescale 1ns/1ns

module microstore_rom (
	input  logic [ucode_pkg::uaddr_w-1:0] upc,
	input  ucode_pkg::opcode_t            opcode,
	output ucode_pkg::ucode_word_t        ucw,
	output logic [ucode_pkg::uaddr_w-1:0] dispatch_addr
);

	// packs the fields of one microword in struct order
	function automatic ucode_pkg::ucode_word_t uword(
		input ucode_pkg::alu_op_t             alu_op,
		input logic                           acc_we,
		input logic                           cnt_load,
		input logic                           cnt_dec,
		input ucode_pkg::next_sel_t           next_sel,
		input logic [ucode_pkg::uaddr_w-1:0]  next_addr,
		input logic                           done
	);
		uword = '{alu_op, acc_we, cnt_load, cnt_dec, next_sel, next_addr, done};
	endfunction

	//####################
	// control words
	always_comb begin
		case (upc)
			ucode_pkg::uaddr_idle:
				ucw = uword(ucode_pkg::alu_pass_acc, 1'b0, 1'b0, 1'b0,
					ucode_pkg::nx_dispatch, ucode_pkg::uaddr_idle, 1'b0);
			ucode_pkg::ua_clr:
				ucw = uword(ucode_pkg::alu_zero, 1'b1, 1'b0, 1'b0,
					ucode_pkg::nx_jump, ucode_pkg::uaddr_idle, 1'b1);
			ucode_pkg::ua_load:
				ucw = uword(ucode_pkg::alu_operand, 1'b1, 1'b0, 1'b0,
					ucode_pkg::nx_jump, ucode_pkg::uaddr_idle, 1'b1);
			ucode_pkg::ua_add:
				ucw = uword(ucode_pkg::alu_add, 1'b1, 1'b0, 1'b0,
					ucode_pkg::nx_jump, ucode_pkg::uaddr_idle, 1'b1);
			ucode_pkg::ua_sub:
				ucw = uword(ucode_pkg::alu_sub, 1'b1, 1'b0, 1'b0,
					ucode_pkg::nx_jump, ucode_pkg::uaddr_idle, 1'b1);
			ucode_pkg::ua_xor:
				ucw = uword(ucode_pkg::alu_xor, 1'b1, 1'b0, 1'b0,
					ucode_pkg::nx_jump, ucode_pkg::uaddr_idle, 1'b1);
			ucode_pkg::ua_nop: // unassigned opcodes finish without touching acc
				ucw = uword(ucode_pkg::alu_pass_acc, 1'b0, 1'b0, 1'b0,
					ucode_pkg::nx_jump, ucode_pkg::uaddr_idle, 1'b1);
			ucode_pkg::ua_shl_load: // count tested on the value being loaded
				ucw = uword(ucode_pkg::alu_pass_acc, 1'b0, 1'b1, 1'b0,
					ucode_pkg::nx_loop, ucode_pkg::ua_shl_loop, 1'b0);
			ucode_pkg::ua_shl_skip:
				ucw = uword(ucode_pkg::alu_pass_acc, 1'b0, 1'b0, 1'b0,
					ucode_pkg::nx_jump, ucode_pkg::uaddr_idle, 1'b1);
			ucode_pkg::ua_shl_loop:
				ucw = uword(ucode_pkg::alu_shl1, 1'b1, 1'b0, 1'b1,
					ucode_pkg::nx_loop, ucode_pkg::ua_shl_loop, 1'b0);
			ucode_pkg::ua_shl_done:
				ucw = uword(ucode_pkg::alu_pass_acc, 1'b0, 1'b0, 1'b0,
					ucode_pkg::nx_jump, ucode_pkg::uaddr_idle, 1'b1);
			default: // stray address ends the instruction
				ucw = uword(ucode_pkg::alu_pass_acc, 1'b0, 1'b0, 1'b0,
					ucode_pkg::nx_jump, ucode_pkg::uaddr_idle, 1'b1);
		endcase
	end

	//####################
	// dispatch table
	always_comb begin
		case (opcode)
			ucode_pkg::op_clr:  dispatch_addr = ucode_pkg::ua_clr;
			ucode_pkg::op_load: dispatch_addr = ucode_pkg::ua_load;
			ucode_pkg::op_add:  dispatch_addr = ucode_pkg::ua_add;
			ucode_pkg::op_sub:  dispatch_addr = ucode_pkg::ua_sub;
			ucode_pkg::op_xor:  dispatch_addr = ucode_pkg::ua_xor;
			ucode_pkg::op_shl:  dispatch_addr = ucode_pkg::ua_shl_load;
			default:            dispatch_addr = ucode_pkg::ua_nop;
		endcase
	end

endmodule

//--- ucode_pkg.sv
//####################
// types, constants and microword layout shared by every block of the control unit
// compile it before any other source file
//####################
package ucode_pkg;

	//####################
	// widths
	localparam int uaddr_w    = 7;
	localparam int data_w     = 8;
	localparam int cnt_w      = 3;
	localparam int err_cnt_w  = 4;
	localparam int done_cnt_w = 8;
	localparam int apb_addr_w = 4;
	localparam int apb_data_w = 32;

	//####################
	// register map, byte offsets on the APB side
	localparam logic [apb_addr_w-1:0] reg_instr  = 4'h0;
	localparam logic [apb_addr_w-1:0] reg_acc    = 4'h4;
	localparam logic [apb_addr_w-1:0] reg_status = 4'h8;

	typedef enum logic [2:0] {
		op_clr  = 3'd0,
		op_load = 3'd1,
		op_add  = 3'd2,
		op_sub  = 3'd3,
		op_xor  = 3'd4,
		op_shl  = 3'd5 // shift left by shamt, runs as a counted loop
	} opcode_t;

	typedef enum logic [2:0] {
		alu_pass_acc = 3'd0,
		alu_zero     = 3'd1,
		alu_operand  = 3'd2,
		alu_add      = 3'd3,
		alu_sub      = 3'd4,
		alu_xor      = 3'd5,
		alu_shl1     = 3'd6
	} alu_op_t;

	// how the sequencer picks the next micro-address
	typedef enum logic [1:0] {
		nx_seq      = 2'd0,
		nx_jump     = 2'd1,
		nx_dispatch = 2'd2,
		nx_loop     = 2'd3 // next_addr while the count stays nonzero
	} next_sel_t;

	// one microstore entry, 16 bits
	typedef struct packed {
		alu_op_t              alu_op;
		logic                 acc_we;
		logic                 cnt_load;
		logic                 cnt_dec;
		next_sel_t            next_sel;
		logic [uaddr_w-1:0]   next_addr;
		logic                 done;     // last word of an instruction
	} ucode_word_t;

	typedef struct packed {
		opcode_t             opcode;
		logic [cnt_w-1:0]    shamt;
		logic [data_w-1:0]   operand;
	} instr_t;

	typedef struct packed {
		logic                  busy;
		logic [err_cnt_w-1:0]  err_cnt;
		logic [done_cnt_w-1:0] done_cnt;
	} status_t;

	//####################
	// microprogram entry points
	localparam logic [uaddr_w-1:0] uaddr_idle  = 7'd0;
	localparam logic [uaddr_w-1:0] ua_clr      = 7'd1;
	localparam logic [uaddr_w-1:0] ua_load     = 7'd2;
	localparam logic [uaddr_w-1:0] ua_add      = 7'd3;
	localparam logic [uaddr_w-1:0] ua_sub      = 7'd4;
	localparam logic [uaddr_w-1:0] ua_xor      = 7'd5;
	localparam logic [uaddr_w-1:0] ua_nop      = 7'd6;
	localparam logic [uaddr_w-1:0] ua_shl_load = 7'd8;
	localparam logic [uaddr_w-1:0] ua_shl_skip = 7'd9;  // exit taken when shamt is zero
	localparam logic [uaddr_w-1:0] ua_shl_loop = 7'd10;
	localparam logic [uaddr_w-1:0] ua_shl_done = 7'd11;

endpackage
